/* bench/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release just after the fifth rising edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end
endmodule : clock_gen

/* bench/l1_cache_asserts.sv */
module l1_cache_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        mem_read,
    input logic                        mem_write,
    input logic                        mem_resp,
    input logic                        l2_read,
    input logic                        l2_write,
    input logic                        l2_resp,
    input lc3b_types::lc3b_word        l2_address,
    input lc3b_types::lc3b_cacheline   l2_wdata
);
    timeunit 1ns;
    timeprecision 100ps;

    l2_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(l2_read && l2_write))
        else $error("l2_read and l2_write are high together");

    // a held l2 request keeps address and data until its response
    l2_request_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (l2_read || l2_write) && !l2_resp |=> $stable(l2_address) && $stable(l2_wdata))
        else $error("l2 address or write data changed while the request was held");

    mem_resp_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |-> (mem_read || mem_write))
        else $error("mem_resp raised without a cpu request");

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !mem_resp && !l2_read && !l2_write)
        else $error("cache not idle in the first cycle after reset");
endmodule : l1_cache_asserts

/* bench/l1_cache_tb.sv */
module l1_cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [3:0][8:0] TAG_POOL = {9'h1e3, 9'h152, 9'h0a1, 9'h040};

    logic clk, rst_n;
    logic mem_read, mem_write, mem_resp;
    logic l2_read, l2_write, l2_resp;
    logic [1:0] mem_byte_enable;
    lc3b_types::lc3b_word mem_address, mem_wdata, mem_rdata, l2_address;
    lc3b_types::lc3b_cacheline l2_rdata, l2_wdata;

    // sparse l2 lines and the byte shadow used by the reference
    lc3b_types::lc3b_cacheline l2_mem [lc3b_types::lc3b_word];
    logic [7:0] shadow [lc3b_types::lc3b_word];

    int l2_reads = 0;
    int l2_writes = 0;
    lc3b_types::lc3b_word rd_addr, wr_addr;
    lc3b_types::lc3b_cacheline wr_line;

    clock_gen u_clock_gen (.clk, .rst_n);

    l1_cache dut (
        .clk, .rst_n,
        .mem_read, .mem_write, .mem_address, .mem_wdata, .mem_byte_enable,
        .mem_resp, .mem_rdata,
        .l2_resp, .l2_rdata, .l2_read, .l2_write, .l2_address, .l2_wdata
    );

    bind l1_cache l1_cache_asserts u_asserts (
        .clk(clk), .rst_n(rst_n), .mem_read(mem_read), .mem_write(mem_write),
        .mem_resp(mem_resp), .l2_read(l2_read), .l2_write(l2_write),
        .l2_resp(l2_resp), .l2_address(l2_address), .l2_wdata(l2_wdata)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [7:0] shadow_byte(input lc3b_types::lc3b_word a);
        return shadow.exists(a) ? shadow[a] : 8'h00;
    endfunction

    // low byte sits at the even address
    function automatic lc3b_types::lc3b_word expected_read(input lc3b_types::lc3b_word a);
        return {shadow_byte({a[15:1], 1'b1}), shadow_byte({a[15:1], 1'b0})};
    endfunction

    function automatic lc3b_types::lc3b_cacheline expected_line(input lc3b_types::lc3b_word a);
        lc3b_types::lc3b_cacheline line;
        line = '0;
        for (int i = 0; i < 16; i++)
            line = {shadow_byte({a[15:4], 4'(i)}), line[127:8]};
        return line;
    endfunction

    task automatic wait_resp();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!mem_resp) begin
            cycles++;
            if (cycles >= TIMEOUT_CYCLES)
                abort_run($sformatf("timeout: no mem_resp for address %h", mem_address));
            @(negedge clk);
        end
    endtask

    task automatic access(input logic is_write, input lc3b_types::lc3b_word addr,
                          input lc3b_types::lc3b_word data, input logic [1:0] be);
        @(posedge clk);
        #1;
        mem_address     = addr;
        mem_wdata       = data;
        mem_byte_enable = be;
        mem_read        = !is_write;
        mem_write       = is_write;
        if (is_write && be[0])
            shadow[{addr[15:1], 1'b0}] = data[7:0];
        if (is_write && be[1])
            shadow[{addr[15:1], 1'b1}] = data[15:8];
        wait_resp();
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    // ************************************************************************
    // l2 memory model answering after 1 to 6 cycles
    // ************************************************************************
    initial begin : l2_model
        int unsigned delay;
        l2_resp  = 1'b0;
        l2_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            l2_resp = 1'b0;
            if (rst_n && (l2_read || l2_write)) begin
                delay = $urandom_range(6, 1);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                if (l2_write) begin
                    l2_writes++;
                    wr_addr = l2_address;
                    wr_line = l2_wdata;
                    l2_mem[l2_address] = l2_wdata;
                end else begin
                    l2_reads++;
                    rd_addr = l2_address;
                    l2_rdata = l2_mem.exists(l2_address) ? l2_mem[l2_address] : '0;
                end
                l2_resp = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && mem_resp && mem_read) begin
            assert (mem_rdata === expected_read(mem_address))
            else abort_run($sformatf("[FAIL] %0t: read at %h returned %h, expected %h",
                                     $time, mem_address, mem_rdata,
                                     expected_read(mem_address)));
        end
    end

    // ************************************************************************
    // stimulus
    // ************************************************************************
    initial begin : stimulus
        lc3b_types::lc3b_word a_addr, b_addr, c_addr, addr;
        logic [31:0] r;
        int cycles;
        int wr_before;
        void'($urandom(32'h105518c8));
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = 2'b00;
        cycles = 0;
        while (!rst_n) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20)
                abort_run("reset was never released");
        end

        repeat (3) begin
            @(negedge clk);
            assert (!mem_resp && !l2_read && !l2_write)
            else abort_run($sformatf("[FAIL] %0t: cache not idle after reset", $time));
        end

        // cold miss then hits on the same line
        access(1'b0, 16'h1234, '0, 2'b00);
        assert (l2_reads == 1 && rd_addr == 16'h1230)
        else abort_run($sformatf("[FAIL] %0t: cold miss gave %0d reads, last at %h",
                                 $time, l2_reads, rd_addr));
        access(1'b0, 16'h123a, '0, 2'b00);
        access(1'b1, 16'h1234, 16'hbeef, 2'b01);
        access(1'b1, 16'h1236, 16'hcafe, 2'b10);
        access(1'b1, 16'h123e, 16'h5a5a, 2'b11);
        access(1'b0, 16'h1234, '0, 2'b00);
        access(1'b0, 16'h1236, '0, 2'b00);
        access(1'b0, 16'h123e, '0, 2'b00);
        assert (l2_reads == 1 && l2_writes == 0)
        else abort_run($sformatf("[FAIL] %0t: l2 traffic on a resident line", $time));

        // three tags at index 5 with the first one dirty
        a_addr = {9'h011, 3'd5, 4'h6};
        b_addr = {9'h022, 3'd5, 4'h0};
        c_addr = {9'h033, 3'd5, 4'h2};
        access(1'b1, a_addr, 16'h1357, 2'b11);
        access(1'b0, b_addr, '0, 2'b00);
        wr_before = l2_writes;
        access(1'b0, c_addr, '0, 2'b00);
        assert (l2_writes == wr_before + 1 && wr_addr == {a_addr[15:4], 4'h0}
                && wr_line == expected_line(a_addr))
        else abort_run($sformatf("[FAIL] %0t: write-back at %h with %h", $time,
                                 wr_addr, wr_line));
        access(1'b0, a_addr, '0, 2'b00);

        repeat (400) begin
            r = $urandom;
            addr = {TAG_POOL[r[1:0]], r[4:2], r[7:5], 1'b0};
            access(r[8], addr, r[31:16], r[10:9]);
        end

        $display("Simulation passed");
        $finish;
    end
endmodule : l1_cache_tb

/* l1_cache.f */
+incdir+src
src/lc3b_types.sv
src/l1_cache_control.sv
src/l1_cache_datapath.sv
src/l1_cache.sv
bench/clock_gen.sv
bench/l1_cache_asserts.sv
bench/l1_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module l1_cache_tb -Mdir obj_dir -f l1_cache.f

status=0
./obj_dir/Vl1_cache_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "testbench reported failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation passed" sim.log; then
    echo "simulation ended abnormally, exit status $status"
    exit 1
fi

/* src/l1_cache.sv */
module l1_cache (
    input  logic                        clk,
    input  logic                        rst_n,

    // cpu side
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  lc3b_types::lc3b_word        mem_address,
    input  lc3b_types::lc3b_word        mem_wdata,
    input  logic [1:0]                  mem_byte_enable,
    output logic                        mem_resp,
    output lc3b_types::lc3b_word        mem_rdata,

    // l2 side
    input  logic                        l2_resp,
    input  lc3b_types::lc3b_cacheline   l2_rdata,
    output logic                        l2_read,
    output logic                        l2_write,
    output lc3b_types::lc3b_word        l2_address,
    output lc3b_types::lc3b_cacheline   l2_wdata
);

    logic load_lru, lru_set, l2wdata_sel;
    logic load_d0, load_v0, load_td0, d_set0, v_set0;
    logic load_d1, load_v1, load_td1, d_set1, v_set1;
    logic hit0, hit1, d_in0, d_in1, v_in0, v_in1, lru_in;

    lc3b_types::l2addr_sel_t     l2addr_sel;
    lc3b_types::lc3b_word        l2_address_inter;
    lc3b_types::lc3b_cacheline   l2_wdata_inter;

    l1_cache_control u_control (
        .clk, .rst_n,
        .lru_in, .d_in0, .d_in1, .v_in0, .v_in1, .hit0, .hit1,
        .load_lru, .lru_set, .l2wdata_sel,
        .load_d0, .load_v0, .load_td0, .d_set0, .v_set0,
        .load_d1, .load_v1, .load_td1, .d_set1, .v_set1,
        .l2addr_sel,
        .mem_read, .mem_write, .mem_resp,
        .l2_resp, .l2_address_inter, .l2_wdata_inter,
        .l2_read, .l2_write, .l2_address, .l2_wdata
    );

    l1_cache_datapath u_datapath (
        .clk, .rst_n,
        .mem_address, .mem_wdata, .mem_byte_enable, .mem_rdata,
        .l2_rdata,
        .load_lru, .lru_set, .l2wdata_sel,
        .load_d0, .load_v0, .load_td0, .d_set0, .v_set0,
        .load_d1, .load_v1, .load_td1, .d_set1, .v_set1,
        .l2addr_sel,
        .hit0, .hit1, .d_in0, .d_in1, .v_in0, .v_in1, .lru_in,
        .l2_address_inter, .l2_wdata_inter
    );

endmodule : l1_cache

/* src/l1_cache_control.sv */
module l1_cache_control (
    input  logic                        clk,
    input  logic                        rst_n,

    // datapath status
    input  logic                        lru_in,
    input  logic                        d_in0,
    input  logic                        d_in1,
    input  logic                        v_in0,
    input  logic                        v_in1,
    input  logic                        hit0,
    input  logic                        hit1,

    // datapath strobes
    output logic                        load_lru,
    output logic                        lru_set,
    output logic                        l2wdata_sel,
    output logic                        load_d0,
    output logic                        load_v0,
    output logic                        load_td0,
    output logic                        d_set0,
    output logic                        v_set0,
    output logic                        load_d1,
    output logic                        load_v1,
    output logic                        load_td1,
    output logic                        d_set1,
    output logic                        v_set1,
    output lc3b_types::l2addr_sel_t     l2addr_sel,

    // cpu side
    input  logic                        mem_read,
    input  logic                        mem_write,
    output logic                        mem_resp,

    // l2 side
    input  logic                        l2_resp,
    input  lc3b_types::lc3b_word        l2_address_inter,
    input  lc3b_types::lc3b_cacheline   l2_wdata_inter,
    output logic                        l2_read,
    output logic                        l2_write,
    output lc3b_types::lc3b_word        l2_address,
    output lc3b_types::lc3b_cacheline   l2_wdata
);

    lc3b_types::cache_state_t state;
    lc3b_types::cache_state_t next_state;

    logic req;
    logic victim_dirty;
    logic victim_valid;

    // exactly one of read or write
    assign req = mem_read ^ mem_write;

    assign victim_dirty = lru_in ? d_in1 : d_in0;
    assign victim_valid = lru_in ? v_in1 : v_in0;

    // ************************************************************************
    // state actions
    // ************************************************************************
    always_comb begin : state_actions
        load_lru    = 1'b0;
        lru_set     = 1'b0;
        l2wdata_sel = 1'b0;
        load_d0     = 1'b0;
        load_v0     = 1'b0;
        load_td0    = 1'b0;
        d_set0      = 1'b0;
        v_set0      = 1'b0;
        load_d1     = 1'b0;
        load_v1     = 1'b0;
        load_td1    = 1'b0;
        d_set1      = 1'b0;
        v_set1      = 1'b0;
        l2addr_sel  = lc3b_types::addr_cpu;
        mem_resp    = 1'b0;
        l2_read     = 1'b0;
        l2_write    = 1'b0;

        case (state)
            lc3b_types::process_request: begin
                if (hit0 && req) begin
                    if (mem_write) begin
                        d_set0   = 1'b1;
                        load_d0  = 1'b1;
                        load_td0 = 1'b1;
                    end
                    // way 1 becomes the victim
                    lru_set  = 1'b1;
                    load_lru = 1'b1;
                    mem_resp = 1'b1;
                end else if (hit1 && req) begin
                    if (mem_write) begin
                        d_set1   = 1'b1;
                        load_d1  = 1'b1;
                        load_td1 = 1'b1;
                    end
                    lru_set     = 1'b0;
                    load_lru    = 1'b1;
                    mem_resp    = 1'b1;
                    l2wdata_sel = 1'b1;
                end
            end
            lc3b_types::fetch_cline: begin
                l2_read = 1'b1;
                // fill the victim way, clean and valid
                if (lru_in == 1'b0) begin
                    v_set0   = 1'b1;
                    load_v0  = l2_resp;
                    load_d0  = l2_resp;
                    load_td0 = l2_resp;
                end else begin
                    v_set1   = 1'b1;
                    load_v1  = l2_resp;
                    load_d1  = l2_resp;
                    load_td1 = l2_resp;
                end
            end
            lc3b_types::write_back: begin
                l2_write = 1'b1;
            end
            // evict_cline only spends a cycle before the fill
            default: ;
        endcase

        // victim line and address are registered one cycle ahead of write_back
        if (next_state == lc3b_types::write_back) begin
            l2wdata_sel = lru_in;
            l2addr_sel  = lru_in ? lc3b_types::addr_way1 : lc3b_types::addr_way0;
        end
    end

    // ************************************************************************
    // next state
    // ************************************************************************
    always_comb begin : next_state_logic
        next_state = state;

        case (state)
            lc3b_types::process_request: begin
                if (!(hit0 || hit1) && req) begin
                    if (victim_dirty)
                        next_state = lc3b_types::write_back;
                    else if (victim_valid)
                        next_state = lc3b_types::evict_cline;
                    else
                        next_state = lc3b_types::fetch_cline;
                end
            end
            lc3b_types::evict_cline: begin
                next_state = lc3b_types::fetch_cline;
            end
            lc3b_types::fetch_cline: begin
                if (l2_resp)
                    next_state = lc3b_types::process_request;
            end
            lc3b_types::write_back: begin
                if (l2_resp)
                    next_state = lc3b_types::fetch_cline;
            end
            default: next_state = lc3b_types::process_request;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= lc3b_types::process_request;
        else
            state <= next_state;
    end

    // registered l2 address and write data
    always_ff @(posedge clk) begin
        l2_address <= l2_address_inter;
        l2_wdata   <= l2_wdata_inter;
    end

endmodule : l1_cache_control

/* src/l1_cache_datapath.sv */
`include "l1_cache_defs.svh"

module l1_cache_datapath (
    input  logic                        clk,
    input  logic                        rst_n,

    // cpu side
    input  lc3b_types::lc3b_word        mem_address,
    input  lc3b_types::lc3b_word        mem_wdata,
    input  logic [1:0]                  mem_byte_enable,
    output lc3b_types::lc3b_word        mem_rdata,

    // fill data from l2
    input  lc3b_types::lc3b_cacheline   l2_rdata,

    // strobes from control
    input  logic                        load_lru,
    input  logic                        lru_set,
    input  logic                        l2wdata_sel,
    input  logic                        load_d0,
    input  logic                        load_v0,
    input  logic                        load_td0,
    input  logic                        d_set0,
    input  logic                        v_set0,
    input  logic                        load_d1,
    input  logic                        load_v1,
    input  logic                        load_td1,
    input  logic                        d_set1,
    input  logic                        v_set1,
    input  lc3b_types::l2addr_sel_t     l2addr_sel,

    // status to control
    output logic                        hit0,
    output logic                        hit1,
    output logic                        d_in0,
    output logic                        d_in1,
    output logic                        v_in0,
    output logic                        v_in1,
    output logic                        lru_in,
    output lc3b_types::lc3b_word        l2_address_inter,
    output lc3b_types::lc3b_cacheline   l2_wdata_inter
);

    localparam int WORD_SEL_BITS = $clog2(`L1_WORDS_PER_LINE);

    // ************************************************************************
    // arrays, indexed [way][set]
    // ************************************************************************
    lc3b_types::lc3b_tag         tag_arr   [2][`L1_SETS];
    lc3b_types::lc3b_cacheline   data_arr  [2][`L1_SETS];
    logic [`L1_SETS-1:0]         valid_arr [2];
    logic [`L1_SETS-1:0]         dirty_arr [2];
    logic [`L1_SETS-1:0]         lru_arr;

    lc3b_types::lc3b_tag         tag;
    lc3b_types::lc3b_index       idx;
    logic [WORD_SEL_BITS-1:0]    word_sel;

    lc3b_types::lc3b_tag         way_tag   [2];
    lc3b_types::lc3b_cacheline   way_line  [2];
    lc3b_types::lc3b_cacheline   fill_line [2];

    logic [1:0] hit;
    logic [1:0] load_td;
    logic [1:0] load_v;
    logic [1:0] load_d;
    logic [1:0] v_set;
    logic [1:0] d_set;

    // merge the enabled bytes of one word into a line
    function automatic lc3b_types::lc3b_cacheline merge_word(
        input lc3b_types::lc3b_cacheline line,
        input lc3b_types::lc3b_word      wdata,
        input logic [1:0]                be,
        input logic [WORD_SEL_BITS-1:0]  sel
    );
        lc3b_types::lc3b_cacheline merged;
        merged = line;
        if (be[0])
            merged[16*sel +: 8] = wdata[7:0];
        if (be[1])
            merged[16*sel + 8 +: 8] = wdata[15:8];
        return merged;
    endfunction

    assign tag      = mem_address[15 -: `L1_TAG_BITS];
    assign idx      = mem_address[`L1_OFFSET_BITS +: `L1_INDEX_BITS];
    assign word_sel = mem_address[`L1_OFFSET_BITS-1:1];

    assign load_td = {load_td1, load_td0};
    assign load_v  = {load_v1, load_v0};
    assign load_d  = {load_d1, load_d0};
    assign v_set   = {v_set1, v_set0};
    assign d_set   = {d_set1, d_set0};

    // combinational read of both ways at the current index
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_tag[w]  = tag_arr[w][idx];
            way_line[w] = data_arr[w][idx];
            hit[w]      = valid_arr[w][idx] && (way_tag[w] == tag);
            // a load on a hit is a cpu write, otherwise a fill
            if (hit[w])
                fill_line[w] = merge_word(way_line[w], mem_wdata, mem_byte_enable, word_sel);
            else
                fill_line[w] = l2_rdata;
        end
    end

    assign hit0   = hit[0];
    assign hit1   = hit[1];
    assign v_in0  = valid_arr[0][idx];
    assign v_in1  = valid_arr[1][idx];
    assign d_in0  = dirty_arr[0][idx];
    assign d_in1  = dirty_arr[1][idx];
    assign lru_in = lru_arr[idx];

    // ************************************************************************
    // array updates
    // ************************************************************************
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (load_td[w]) begin
                tag_arr[w][idx]  <= tag;
                data_arr[w][idx] <= fill_line[w];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                valid_arr[w] <= '0;
                dirty_arr[w] <= '0;
            end
            lru_arr <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (load_v[w])
                    valid_arr[w][idx] <= v_set[w];
                if (load_d[w])
                    dirty_arr[w][idx] <= d_set[w];
            end
            if (load_lru)
                lru_arr[idx] <= lru_set;
        end
    end

    // read word and write-back line from the selected way
    assign mem_rdata      = way_line[l2wdata_sel][16*word_sel +: 16];
    assign l2_wdata_inter = way_line[l2wdata_sel];

    always_comb begin
        case (l2addr_sel)
            lc3b_types::addr_way0:
                l2_address_inter = {way_tag[0], idx, {`L1_OFFSET_BITS{1'b0}}};
            lc3b_types::addr_way1:
                l2_address_inter = {way_tag[1], idx, {`L1_OFFSET_BITS{1'b0}}};
            default:
                l2_address_inter = {tag, idx, {`L1_OFFSET_BITS{1'b0}}};
        endcase
    end

endmodule : l1_cache_datapath

/* src/l1_cache_defs.svh */
`ifndef L1_CACHE_DEFS_SVH
`define L1_CACHE_DEFS_SVH

// ************************************************************************
// address split, tag | index | offset
// ************************************************************************

// byte offset within a 16-byte line
`define L1_OFFSET_BITS 4

// set index
`define L1_INDEX_BITS 3

// remaining upper address bits
`define L1_TAG_BITS 9

// cache geometry
`define L1_SETS 8
`define L1_WORDS_PER_LINE 8

`endif

/* src/lc3b_types.sv */
`include "l1_cache_defs.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [127:0] lc3b_cacheline;
    typedef logic [`L1_TAG_BITS-1:0] lc3b_tag;
    typedef logic [`L1_INDEX_BITS-1:0] lc3b_index;

    // miss handling controller
    typedef enum logic [1:0] {
        process_request,
        evict_cline,
        write_back,
        fetch_cline
    } cache_state_t;

    // source of the line address sent to L2
    typedef enum logic [1:0] {
        addr_cpu,
        addr_way0,
        addr_way1
    } l2addr_sel_t;

endpackage : lc3b_types
